// ==== design/rx_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types and sizes of the rx sample path
// at most MAX_CHANS channels, gain field is sized for that
// nsamps and decim are 7 bit counts, 0 is never stored
// buffer words are 16 bits, timestamp is 48 bits
////////////////////////////////////////////////////////////

package rx_pkg;

	localparam int ADC_BITS       = 14;   // signed adc sample
	localparam int IQ_BITS        = 24;   // one I or Q value
	localparam int TICK_BITS      = 48;   // sample timestamp
	localparam int BUF_WORD_BITS  = 16;   // buffer word and frame counter
	localparam int CFG_CNT_BITS   = 7;    // nsamps and decim, 1..127
	localparam int GAIN_BITS      = 2;    // left shift 0..3
	localparam int MAX_CHANS      = 4;
	localparam int WORDS_PER_CHAN = 3;    // I low, Q low, both high bytes
	localparam int TAIL_WORDS     = 4;    // 3 timestamp words + frame counter

	// command codes on the host port
	typedef enum logic [1:0]
	{
		SET_NSAMPS = 2'd0,
		SET_DECIM  = 2'd1,
		SET_GAIN   = 2'd2
	} rx_op_e;

	typedef struct packed
	{
		rx_op_e      op;
		logic [3:0]  chan;    // only for SET_GAIN
		logic [15:0] data;
	} rx_cmd_t;               // 22 bits

	typedef struct packed
	{
		logic [IQ_BITS-1:0] i;
		logic [IQ_BITS-1:0] q;
	} iq_pair_t;              // 48 bits

	// one 48 bit word, either a channel pair or a tick count
	typedef union packed
	{
		iq_pair_t             iq;
		logic [TICK_BITS-1:0] ticks;
	} rx_word48_u;

	typedef logic [BUF_WORD_BITS-1:0] buf_word_t;

	typedef struct packed
	{
		logic [CFG_CNT_BITS-1:0]                  nsamps;  // groups per frame
		logic [CFG_CNT_BITS-1:0]                  decim;   // samples per group
		logic [MAX_CHANS-1:0][GAIN_BITS-1:0]      gain;    // shift per channel
	} rx_cfg_t;               // 22 bits

endpackage

// ==== design/rx_chan_bank.sv ====
////////////////////////////////////////////////////////////
// bank of decimating channels, one shared window phase
// I is the window sum, Q the sum with alternating sign
// both scaled by the channel gain shift, kept to 24 bits
// at decim 1, valid samples must not come back to back
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rx_chan_bank #(
	parameter int RX_CHANS = 4
) (
	input  logic                               cpu_clk,
	input  logic                               reset_bufs_A,
	input  logic                               adc_valid_i,
	input  logic [rx_pkg::ADC_BITS-1:0]        adc_data_i,
	input  rx_pkg::rx_cfg_t                    cfg_i,
	output logic                               avail_o,
	output rx_pkg::iq_pair_t [RX_CHANS-1:0]    pairs_o
);

	localparam int IQW = rx_pkg::IQ_BITS;
	localparam int ADW = rx_pkg::ADC_BITS;

	logic [rx_pkg::CFG_CNT_BITS-1:0] phase;   // sample index inside window
	logic                            win_end;
	logic [IQW-1:0]                  samp_ext;
	logic [IQW-1:0]                  acc_i [RX_CHANS];
	logic [IQW-1:0]                  acc_q [RX_CHANS];
	logic [IQW-1:0]                  sum_i [RX_CHANS];
	logic [IQW-1:0]                  sum_q [RX_CHANS];

	assign samp_ext = {{(IQW-ADW){adc_data_i[ADW-1]}}, adc_data_i};  // sign extend
	assign win_end  = (phase >= (cfg_i.decim - 1'b1));   // >= covers a decim drop mid window

	// window sums including the current sample
	always_comb
	begin
		logic [IQW-1:0] term;
		for (int c = 0; c < RX_CHANS; c++)
		begin
			term     = samp_ext << cfg_i.gain[c];   // gain applied per sample
			sum_i[c] = acc_i[c] + term;
			sum_q[c] = phase[0] ? (acc_q[c] - term) : (acc_q[c] + term);  // even index adds
		end
	end

	////////////////////////////////////////////////////////////
	// phase, accumulators and the avail pulse

	always_ff @(posedge cpu_clk)
	begin
		if (reset_bufs_A)
		begin
			phase   <= '0;
			avail_o <= 1'b0;
			for (int c = 0; c < RX_CHANS; c++)
			begin
				acc_i[c] <= '0;
				acc_q[c] <= '0;
			end
		end
		else
		begin
			avail_o <= adc_valid_i && win_end;   // one cycle after the last sample
			if (adc_valid_i)
			begin
				phase <= win_end ? '0 : phase + 1'b1;
				for (int c = 0; c < RX_CHANS; c++)
				begin
					acc_i[c] <= win_end ? '0 : sum_i[c];
					acc_q[c] <= win_end ? '0 : sum_q[c];
				end
			end
		end
	end

	// results held until the next window closes
	always_ff @(posedge cpu_clk)
	begin
		if (adc_valid_i && win_end)
		begin
			for (int c = 0; c < RX_CHANS; c++)
			begin
				pairs_o[c].i <= sum_i[c];
				pairs_o[c].q <= sum_q[c];
			end
		end
	end

	// the packer counts one group per pulse, a stretched pulse would double count
	a_avail_single: assert property (@(posedge cpu_clk) disable iff (reset_bufs_A)
		avail_o |=> !avail_o);

endmodule

// ==== design/sample_stamp.sv ====
////////////////////////////////////////////////////////////
// input sample counter and frame counter
// ticks_o holds the count at the latest avail pulse
// both counters restart at 0 on buffer reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sample_stamp (
	input  logic                                cpu_clk,
	input  logic                                reset_bufs_A,
	input  logic                                adc_valid_i,
	input  logic                                avail_i,
	input  logic                                frame_done_i,
	output logic [rx_pkg::TICK_BITS-1:0]        ticks_o,
	output logic [rx_pkg::BUF_WORD_BITS-1:0]    frame_cnt_o
);

	logic [rx_pkg::TICK_BITS-1:0] tick_cnt;   // accepted samples since reset

	always_ff @(posedge cpu_clk)
	begin
		if (reset_bufs_A)
		begin
			tick_cnt    <= '0;
			frame_cnt_o <= '0;
		end
		else
		begin
			if (adc_valid_i)
				tick_cnt <= tick_cnt + 1'b1;
			if (frame_done_i)
				frame_cnt_o <= frame_cnt_o + 1'b1;   // dropped frames count too
		end
	end

	// avail comes the cycle after the window's last sample,
	// so tick_cnt already includes it and nothing newer
	always_ff @(posedge cpu_clk)
	begin
		if (avail_i)
			ticks_o <= tick_cnt;
	end

endmodule

// ==== design/frame_packer.sv ====
////////////////////////////////////////////////////////////
// serializes each group of channel pairs into the buffer
// per channel: I low, Q low, {I high byte, Q high byte}
// last group of a frame adds ticks low/mid/high + frame count
// a group is written whole or dropped whole, drop sets overrun
// avail pulses while a group is being written are ignored
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frame_packer #(
	parameter int RX_CHANS = 4,
	parameter int BUF_AW   = 11
) (
	input  logic                               cpu_clk,
	input  logic                               reset_bufs_A,
	input  rx_pkg::rx_cfg_t                    cfg_i,
	input  logic                               avail_i,
	input  rx_pkg::iq_pair_t [RX_CHANS-1:0]    pairs_i,
	input  logic [rx_pkg::TICK_BITS-1:0]       ticks_i,
	input  logic [rx_pkg::BUF_WORD_BITS-1:0]   frame_cnt_i,
	input  logic [BUF_AW:0]                    free_cnt_i,
	output logic                               wr_en_o,
	output rx_pkg::buf_word_t                  wr_data_o,
	output logic                               frame_done_o,
	output logic                               overrun_o
);

	localparam int CW        = (RX_CHANS > 1) ? $clog2(RX_CHANS) : 1;
	localparam int GRP_WORDS = rx_pkg::WORDS_PER_CHAN * RX_CHANS;
	localparam logic [BUF_AW:0] NEED_GRP  = (BUF_AW+1)'(GRP_WORDS);
	localparam logic [BUF_AW:0] NEED_LAST = (BUF_AW+1)'(GRP_WORDS + rx_pkg::TAIL_WORDS);
	localparam int HI = rx_pkg::IQ_BITS - 1;

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_MOVE,   // channel words
		ST_TS,     // timestamp words
		ST_CTR     // frame counter word
	} state_e;

	state_e                          state;
	logic [CW-1:0]                   chan_ptr;   // channel of the next word
	logic [1:0]                      move_ptr;   // 0 I low, 1 Q low, 2 high bytes
	logic [1:0]                      tsel;       // timestamp word
	logic [rx_pkg::CFG_CNT_BITS-1:0] grp_cnt;    // groups done in this frame
	logic                            last_grp;
	logic                            room;
	rx_pkg::rx_word48_u              src48;
	rx_pkg::buf_word_t               next_word;

	assign last_grp = (grp_cnt >= (cfg_i.nsamps - 1'b1));
	assign room     = (free_cnt_i >= (last_grp ? NEED_LAST : NEED_GRP));  // whole group fits

	////////////////////////////////////////////////////////////
	// word select, same 48 bits seen as a pair or as ticks

	always_comb
	begin
		if (state == ST_TS)
			src48.ticks = ticks_i;
		else
			src48.iq = pairs_i[chan_ptr];   // chan_ptr is 0 in idle
		case (state)
			ST_TS:  next_word = src48.ticks[{tsel, 4'd0} +: 16];   // low word first
			ST_CTR: next_word = frame_cnt_i;
			default:
			begin
				case (move_ptr)
					2'd0:    next_word = src48.iq.i[15:0];
					2'd1:    next_word = src48.iq.q[15:0];
					default: next_word = {src48.iq.i[HI -: 8], src48.iq.q[HI -: 8]};
				endcase
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// sequencer, outputs registered so the first word lands
	// the cycle after avail

	always_ff @(posedge cpu_clk)
	begin
		if (reset_bufs_A)
		begin
			state        <= ST_IDLE;
			chan_ptr     <= '0;
			move_ptr     <= '0;
			tsel         <= '0;
			grp_cnt      <= '0;
			wr_en_o      <= 1'b0;
			frame_done_o <= 1'b0;
			overrun_o    <= 1'b0;
		end
		else
		begin
			wr_en_o      <= 1'b0;
			frame_done_o <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (avail_i && room)
					begin
						wr_en_o  <= 1'b1;   // chan 0 I low
						move_ptr <= 2'd1;
						state    <= ST_MOVE;
					end
					else if (avail_i)
					begin
						overrun_o <= 1'b1;   // sticky until buffer reset
						if (last_grp)
						begin
							grp_cnt      <= '0;
							frame_done_o <= 1'b1;
						end
						else
							grp_cnt <= grp_cnt + 1'b1;
					end
				end
				ST_MOVE:
				begin
					wr_en_o <= 1'b1;
					if (move_ptr == 2'd2)
					begin
						move_ptr <= 2'd0;
						if (chan_ptr == CW'(RX_CHANS-1))
						begin
							chan_ptr <= '0;
							if (last_grp)
								state <= ST_TS;   // no gap before the tail
							else
							begin
								grp_cnt <= grp_cnt + 1'b1;
								state   <= ST_IDLE;
							end
						end
						else
							chan_ptr <= chan_ptr + 1'b1;
					end
					else
						move_ptr <= move_ptr + 1'b1;
				end
				ST_TS:
				begin
					wr_en_o <= 1'b1;
					if (tsel == 2'd2)
					begin
						tsel  <= '0;
						state <= ST_CTR;
					end
					else
						tsel <= tsel + 1'b1;
				end
				default:   // ST_CTR
				begin
					wr_en_o      <= 1'b1;
					frame_done_o <= 1'b1;   // frame counter steps after its word
					grp_cnt      <= '0;
					state        <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge cpu_clk)
	begin
		wr_data_o <= next_word;
	end

	// the room check at group start must keep every write inside the buffer
	a_no_write_full: assert property (@(posedge cpu_clk) disable iff (reset_bufs_A)
		wr_en_o |-> (free_cnt_i != '0));

endmodule

// ==== design/sample_buf.sv ====
////////////////////////////////////////////////////////////
// circular sample memory of 2**BUF_AW words
// writer must check free_cnt_o, a write when full is lost
// a word goes out only with data and a credit in hand
// consumer returns at most CREDITS credits
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sample_buf #(
	parameter int BUF_AW  = 11,
	parameter int CREDITS = 4
) (
	input  logic                cpu_clk,
	input  logic                reset_bufs_A,
	input  logic                wr_en_i,
	input  rx_pkg::buf_word_t   wr_data_i,
	output logic [BUF_AW:0]     free_cnt_o,
	input  logic                credit_i,
	output logic                rd_valid_o,
	output rx_pkg::buf_word_t   rd_data_o
);

	localparam int DEPTH = 2**BUF_AW;
	localparam int CRW   = $clog2(CREDITS+1);

	rx_pkg::buf_word_t mem [DEPTH];
	logic [BUF_AW-1:0] wr_ptr;
	logic [BUF_AW-1:0] rd_ptr;
	logic [BUF_AW:0]   fill;      // words held
	logic [CRW-1:0]    credits;   // words the consumer can still take
	logic              rd_fire;

	assign rd_fire    = (fill != '0) && (credits != '0);
	assign free_cnt_o = (BUF_AW+1)'(DEPTH) - fill;

	////////////////////////////////////////////////////////////
	// pointers, fill level and credit count

	always_ff @(posedge cpu_clk)
	begin
		if (reset_bufs_A)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill       <= '0;
			credits    <= CRW'(CREDITS);   // consumer starts with all slots free
			rd_valid_o <= 1'b0;
		end
		else
		begin
			rd_valid_o <= rd_fire;   // word shows the cycle after the credit check
			if (wr_en_i)
				wr_ptr <= wr_ptr + 1'b1;   // wraps around
			if (rd_fire)
				rd_ptr <= rd_ptr + 1'b1;
			fill    <= fill + (BUF_AW+1)'(wr_en_i) - (BUF_AW+1)'(rd_fire);
			credits <= credits + CRW'(credit_i) - CRW'(rd_fire);
		end
	end

	// memory and read data
	always_ff @(posedge cpu_clk)
	begin
		if (wr_en_i)
			mem[wr_ptr] <= wr_data_i;
		if (rd_fire)
			rd_data_o <= mem[rd_ptr];   // written words are a cycle old at least
	end

	// a returned credit with no word outstanding would push the count past CREDITS
	a_credit_max: assert property (@(posedge cpu_clk) disable iff (reset_bufs_A)
		(credit_i && !rd_fire) |-> (credits < CRW'(CREDITS)));

endmodule

// ==== design/rx_sample_buffer.sv ====
////////////////////////////////////////////////////////////
// rx sample path top, single clock cpu_clk
// RX_CHANS 1..4, all channels share decim and nsamps
// adc source has no back-pressure, overrun_o shows losses
// nsamps or decim written as 0 are stored as 1
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rx_sample_buffer #(
	parameter int RX_CHANS = 4,
	parameter int BUF_AW   = 11,
	parameter int CREDITS  = 4
) (
	input  logic                          cpu_clk,
	input  logic                          reset_bufs_A,
	input  logic                          cmd_valid_i,
	input  rx_pkg::rx_cmd_t               cmd_i,
	input  logic                          adc_valid_i,
	input  logic [rx_pkg::ADC_BITS-1:0]   adc_data_i,
	input  logic                          credit_i,
	output logic                          rd_valid_o,
	output rx_pkg::buf_word_t             rd_data_o,
	output logic                          overrun_o
);

	rx_pkg::rx_cfg_t                       cfg;
	logic [rx_pkg::CFG_CNT_BITS-1:0]       cmd_cnt;     // nsamps/decim from command
	logic                                  avail;
	rx_pkg::iq_pair_t [RX_CHANS-1:0]       pairs;
	logic [rx_pkg::TICK_BITS-1:0]          ticks;
	logic [rx_pkg::BUF_WORD_BITS-1:0]      frame_cnt;
	logic                                  frame_done;
	logic                                  wr_en;
	rx_pkg::buf_word_t                     wr_data;
	logic [BUF_AW:0]                       free_cnt;

	assign cmd_cnt = (cmd_i.data[6:0] == '0) ? 7'd1 : cmd_i.data[6:0];

	////////////////////////////////////////////////////////////
	// command port, live configuration

	always_ff @(posedge cpu_clk)
	begin
		if (reset_bufs_A)
		begin
			cfg.nsamps <= 7'd1;
			cfg.decim  <= 7'd1;
			cfg.gain   <= '0;
		end
		else if (cmd_valid_i)
		begin
			case (cmd_i.op)
				rx_pkg::SET_NSAMPS: cfg.nsamps <= cmd_cnt;
				rx_pkg::SET_DECIM:  cfg.decim  <= cmd_cnt;
				rx_pkg::SET_GAIN:
				begin
					if (cmd_i.chan < rx_pkg::MAX_CHANS)   // higher channel numbers ignored
						cfg.gain[cmd_i.chan[1:0]] <= cmd_i.data[1:0];
				end
				default: ;   // unused code
			endcase
		end
	end

	// producers side by side on the same sample stream
	rx_chan_bank #(.RX_CHANS(RX_CHANS)) i_chan_bank (
		.cpu_clk      (cpu_clk),
		.reset_bufs_A (reset_bufs_A),
		.adc_valid_i  (adc_valid_i),
		.adc_data_i   (adc_data_i),
		.cfg_i        (cfg),
		.avail_o      (avail),
		.pairs_o      (pairs)
	);

	sample_stamp i_stamp (
		.cpu_clk      (cpu_clk),
		.reset_bufs_A (reset_bufs_A),
		.adc_valid_i  (adc_valid_i),
		.avail_i      (avail),
		.frame_done_i (frame_done),
		.ticks_o      (ticks),
		.frame_cnt_o  (frame_cnt)
	);

	frame_packer #(.RX_CHANS(RX_CHANS), .BUF_AW(BUF_AW)) i_packer (
		.cpu_clk      (cpu_clk),
		.reset_bufs_A (reset_bufs_A),
		.cfg_i        (cfg),
		.avail_i      (avail),
		.pairs_i      (pairs),
		.ticks_i      (ticks),
		.frame_cnt_i  (frame_cnt),
		.free_cnt_i   (free_cnt),
		.wr_en_o      (wr_en),
		.wr_data_o    (wr_data),
		.frame_done_o (frame_done),
		.overrun_o    (overrun_o)
	);

	sample_buf #(.BUF_AW(BUF_AW), .CREDITS(CREDITS)) i_buf (
		.cpu_clk      (cpu_clk),
		.reset_bufs_A (reset_bufs_A),
		.wr_en_i      (wr_en),
		.wr_data_i    (wr_data),
		.free_cnt_o   (free_cnt),
		.credit_i     (credit_i),
		.rd_valid_o   (rd_valid_o),
		.rd_data_o    (rd_data_o)
	);

endmodule

// ==== verif/tb_rx_sample_buffer.sv ====
////////////////////////////////////////////////////////////
// testbench for the rx sample path, 4 channels, 64 word buffer
// groups are spaced so each one is written before the next
// window closes, the packer drops avail pulses while busy
// expected stream comes from a model of the window sums
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rx_sample_buffer;

	localparam int CH      = 4;
	localparam int AW      = 6;    // small buffer so it fills fast
	localparam int CREDITS = 4;
	localparam int GAP     = 3*CH + rx_pkg::TAIL_WORDS + 3;   // idle cycles after a window
	localparam int N_CASES = 7;
	localparam logic [31:0] SEED = 32'h2512_f974;

	localparam logic       PAT_RAMP = 1'b0;
	localparam logic       PAT_RAND = 1'b1;
	localparam logic [1:0] CR_FAST  = 2'd0;   // credit back at once
	localparam logic [1:0] CR_SLOW  = 2'd1;   // one credit every 5 cycles
	localparam logic [1:0] CR_HOLD  = 2'd2;   // no credits, buffer fills up

	typedef logic [rx_pkg::ADC_BITS-1:0] adc_t;

	typedef struct packed
	{
		logic [6:0]                                          nsamps;
		logic [6:0]                                          decim;
		logic [rx_pkg::MAX_CHANS-1:0][rx_pkg::GAIN_BITS-1:0] gain;
		logic                                                pat;
		logic [7:0]                                          frames;
		logic [1:0]                                          mode;
	} case_t;

	// nsamps, decim, gains (chan 3 in the top bits), pattern, frames, credits
	case_t cases [N_CASES] = '{
		'{7'd1, 7'd1, 8'h00, PAT_RAMP, 8'd3, CR_FAST},   // frame layout
		'{7'd2, 7'd8, 8'h00, PAT_RAND, 8'd2, CR_FAST},   // decimation sums
		'{7'd2, 7'd4, 8'hE4, PAT_RAND, 8'd2, CR_FAST},   // gains 3,2,1,0
		'{7'd3, 7'd5, 8'h1B, PAT_RAMP, 8'd2, CR_FAST},   // timestamp over 3 groups
		'{7'd1, 7'd8, 8'h55, PAT_RAND, 8'd3, CR_SLOW},   // slow credit return
		'{7'd1, 7'd8, 8'h00, PAT_RAMP, 8'd6, CR_HOLD},   // fill up and overrun
		'{7'd2, 7'd4, 8'h9C, PAT_RAND, 8'd2, CR_FAST}    // resume after buffer reset
	};

	logic              cpu_clk;
	logic              reset_bufs_A;
	logic              cmd_valid_i;
	rx_pkg::rx_cmd_t   cmd_i;
	logic              adc_valid_i;
	adc_t              adc_data_i;
	logic              credit_i;
	logic              rd_valid_o;
	rx_pkg::buf_word_t rd_data_o;
	logic              overrun_o;

	rx_pkg::buf_word_t  rx_q [$];    // words as delivered
	rx_pkg::rx_word48_u exp_q [$];   // expected pairs and timestamps in order
	logic [1:0]         cr_mode;
	int                 outstanding;   // words taken minus credits returned
	int                 slow_wait;
	int                 err_cnt;
	int                 chk_cnt;
	int                 cycle_cnt;
	int                 run_limit;

	rx_sample_buffer #(.RX_CHANS(CH), .BUF_AW(AW), .CREDITS(CREDITS)) i_dut (
		.cpu_clk      (cpu_clk),
		.reset_bufs_A (reset_bufs_A),
		.cmd_valid_i  (cmd_valid_i),
		.cmd_i        (cmd_i),
		.adc_valid_i  (adc_valid_i),
		.adc_data_i   (adc_data_i),
		.credit_i     (credit_i),
		.rd_valid_o   (rd_valid_o),
		.rd_data_o    (rd_data_o),
		.overrun_o    (overrun_o)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever #4 cpu_clk = ~cpu_clk;   // 8 ns period
	end

	////////////////////////////////////////////////////////////
	// compare tasks

	task automatic check_word(input rx_pkg::buf_word_t got, input rx_pkg::buf_word_t exp,
		input string what);
		chk_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("Error %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pair(input rx_pkg::rx_word48_u got, input rx_pkg::rx_word48_u exp,
		input string what);
		chk_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("Error %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		chk_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("Error %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus

	function automatic adc_t next_sample(input logic pat, input int n);
		if (pat == PAT_RAND)
			return adc_t'($urandom);
		return adc_t'(n * 97 - 4000);   // ramp through zero
	endfunction

	task automatic apply_reset();
		@(negedge cpu_clk);
		reset_bufs_A = 1'b1;
		repeat (8) @(negedge cpu_clk);
		reset_bufs_A = 1'b0;
	endtask

	task automatic send_cmd(input rx_pkg::rx_op_e op, input logic [3:0] chan,
		input logic [15:0] data);
		@(negedge cpu_clk);
		cmd_valid_i = 1'b1;
		cmd_i.op    = op;
		cmd_i.chan  = chan;
		cmd_i.data  = data;
		@(negedge cpu_clk);
		cmd_valid_i = 1'b0;
	endtask

	task automatic configure(input case_t tc);
		send_cmd(rx_pkg::SET_NSAMPS, 4'd0, 16'(tc.nsamps));
		send_cmd(rx_pkg::SET_DECIM, 4'd0, 16'(tc.decim));
		for (int c = 0; c < CH; c++)
			send_cmd(rx_pkg::SET_GAIN, 4'(c), 16'(tc.gain[c]));
	endtask

	// drives the samples and builds the expected pairs on the way
	task automatic run_stream(input case_t tc);
		int                 ai [CH];
		int                 aq [CH];
		int                 v;
		int                 ticks;
		adc_t               s;
		rx_pkg::rx_word48_u e;
		ticks = 0;
		for (int f = 0; f < tc.frames; f++)
		begin
			for (int g = 0; g < tc.nsamps; g++)
			begin
				for (int c = 0; c < CH; c++)
				begin
					ai[c] = 0;
					aq[c] = 0;
				end
				for (int k = 0; k < tc.decim; k++)
				begin
					s = next_sample(tc.pat, ticks);
					v = int'($signed(s));
					for (int c = 0; c < CH; c++)
					begin
						ai[c] += v <<< tc.gain[c];
						aq[c] += (k % 2 == 0) ? (v <<< tc.gain[c]) : -(v <<< tc.gain[c]);
					end
					ticks++;
					@(negedge cpu_clk);
					adc_valid_i = 1'b1;
					adc_data_i  = s;
				end
				@(negedge cpu_clk);
				adc_valid_i = 1'b0;
				for (int c = 0; c < CH; c++)
				begin
					e.iq.i = ai[c][23:0];   // 24 bit wrap like the hardware
					e.iq.q = aq[c][23:0];
					exp_q.push_back(e);
				end
				if (g == tc.nsamps - 1)
				begin
					e.ticks = 48'(ticks);   // samples up to this group
					exp_q.push_back(e);
				end
				repeat (GAP) @(negedge cpu_clk);   // let the packer finish the group
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// result checks

	// rebuilds each 48 bit value from its three words
	task automatic check_stream(input case_t tc);
		rx_pkg::buf_word_t  w0;
		rx_pkg::buf_word_t  w1;
		rx_pkg::buf_word_t  w2;
		rx_pkg::rx_word48_u got;
		for (int f = 0; f < tc.frames; f++)
		begin
			for (int g = 0; g < tc.nsamps; g++)
			begin
				for (int c = 0; c < CH; c++)
				begin
					w0 = rx_q.pop_front();
					w1 = rx_q.pop_front();
					w2 = rx_q.pop_front();
					got.iq.i = {w2[15:8], w0};
					got.iq.q = {w2[7:0], w1};
					check_pair(got, exp_q.pop_front(),
						$sformatf("frame %0d group %0d chan %0d", f, g, c));
				end
			end
			w0 = rx_q.pop_front();
			w1 = rx_q.pop_front();
			w2 = rx_q.pop_front();
			got.ticks = {w2, w1, w0};   // low word first
			check_pair(got, exp_q.pop_front(), $sformatf("frame %0d timestamp", f));
			check_word(rx_q.pop_front(), rx_pkg::buf_word_t'(f), $sformatf("frame %0d count", f));
		end
		if (rx_q.size() != 0)
		begin
			err_cnt++;
			$display("%0d words came out beyond the expected frames", rx_q.size());
		end
	endtask

	// no credits came back, only the first CREDITS words got out
	task automatic check_held();
		rx_pkg::rx_word48_u got;
		check_flag(overrun_o, 1'b1, "overrun flag with credits held");
		if (rx_q.size() != CREDITS)
		begin
			err_cnt++;
			$display("%0d words came out while no credits were returned, %0d expected",
				rx_q.size(), CREDITS);
		end
		else
		begin
			got.iq.i = {rx_q[2][15:8], rx_q[0]};
			got.iq.q = {rx_q[2][7:0], rx_q[1]};
			check_pair(got, exp_q[0], "first pair before overrun");
		end
	endtask

	// consumer, takes words and returns credits by mode
	always @(negedge cpu_clk)
	begin
		credit_i = 1'b0;
		if (reset_bufs_A)
		begin
			outstanding = 0;
			slow_wait   = 0;
		end
		else
		begin
			if (rd_valid_o)
			begin
				rx_q.push_back(rd_data_o);
				outstanding++;
				if (outstanding > CREDITS)
				begin
					err_cnt++;
					$display("at %0t ns the DUT sent %0d words beyond the returned credits",
						$time, outstanding - CREDITS);
				end
			end
			slow_wait++;
			if (outstanding > 0 && (cr_mode == CR_FAST || (cr_mode == CR_SLOW && slow_wait >= 5)))
			begin
				credit_i    = 1'b1;
				outstanding--;
				slow_wait   = 0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence

	initial
	begin
		int words;
		int err_before;
		int chk_before;
		reset_bufs_A = 1'b1;
		cmd_valid_i  = 1'b0;
		cmd_i        = '0;
		adc_valid_i  = 1'b0;
		adc_data_i   = '0;
		credit_i     = 1'b0;
		cr_mode      = CR_FAST;
		err_cnt      = 0;
		chk_cnt      = 0;
		void'($urandom(SEED));   // seeds the run once
		for (int t = 0; t < N_CASES; t++)
		begin
			err_before = err_cnt;
			chk_before = chk_cnt;
			rx_q.delete();
			exp_q.delete();
			cr_mode = cases[t].mode;
			apply_reset();   // frame count restarts at 0
			configure(cases[t]);
			run_stream(cases[t]);
			if (cases[t].mode == CR_HOLD)
				check_held();
			else
			begin
				words = cases[t].frames * (cases[t].nsamps * 3 * CH + rx_pkg::TAIL_WORDS);
				while (rx_q.size() < words)
					@(negedge cpu_clk);   // watchdog covers a stall
				check_stream(cases[t]);
				check_flag(overrun_o, 1'b0, "overrun flag");
			end
			$display("case %0d: nsamps %0d decim %0d frames %0d, %0d checks, %0d errors", t,
				cases[t].nsamps, cases[t].decim, cases[t].frames,
				chk_cnt - chk_before, err_cnt - err_before);
		end
		$display("%0d cases, %0d checks, %0d errors", N_CASES, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// watchdog, 4 cycles per input sample plus slack
	initial
	begin
		run_limit = 1000;
		for (int t = 0; t < N_CASES; t++)
			run_limit += 4 * cases[t].frames * cases[t].nsamps * cases[t].decim;
		cycle_cnt = 0;
		while (cycle_cnt < run_limit)
		begin
			@(posedge cpu_clk);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", run_limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== rx_sample_buffer.f ====
design/rx_pkg.sv
design/rx_chan_bank.sv
design/sample_stamp.sv
design/frame_packer.sv
design/sample_buf.sv
design/rx_sample_buffer.sv
verif/tb_rx_sample_buffer.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = tb_rx_sample_buffer
FILELIST  = rx_sample_buffer.f
OBJDIR    = obj_dir
LOG       = sim.log
FAIL_MSG  = TESTBENCH FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "simulator exit status 0" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
